/* Bender.yml */
package:
  name: vidgen

sources:
  - files:
      - rtl/vidGenPkg.sv
      - rtl/rasterTiming.sv
      - rtl/configRegs.sv
      - rtl/fetchAddress.sv
      - rtl/busSequencer.sv
      - rtl/pixelSerializer.sv
      - rtl/vidGen.sv
  - target: test
    files:
      - verif/vidGen_assertions.sv
      - verif/vidGenTb.sv

/* filelist.f */
rtl/vidGenPkg.sv
rtl/rasterTiming.sv
rtl/configRegs.sv
rtl/fetchAddress.sv
rtl/busSequencer.sv
rtl/pixelSerializer.sv
rtl/vidGen.sv
verif/vidGen_assertions.sv
verif/vidGenTb.sv

/* rtl/busSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module busSequencer import vidGenPkg::*; (
    input  wire logic       pixClk,
    input  wire logic       nReset,
    input  rasterPos_t      pos,
    input  vidConfig_t      cfg,
    input  wire logic [15:0] videoAddr,
    input  cpuReq_t         cpu,
    input  wire logic [7:0] statusByte,
    output vramBus_t        vram,
    output logic            regWrite,
    output logic [7:0]      cpuDataOut,
    output logic            cpuDataOe,
    output logic            nCpuDSACK
);

    logic fetchSlot;
    logic cpuServe;
    logic regHit;
    logic served;
    logic fetchChip1;

    // video owns phase 0 of every active group
    assign fetchSlot = pos.hActive && pos.vActive && (pos.phase == 2'd0);

    // a waiting request is taken on the first free edge
    assign cpuServe = cpu.sel && !served && !fetchSlot;
    assign regHit = (cpu.addr == regAddr);

    // register load happens at the same edge in configRegs
    assign regWrite = cpuServe && regHit && !cpu.rnw;

    // ack held until the cpu lets go of the strobe
    assign nCpuDSACK = ~served;

    // buffer select in paged modes, address bit 15 in linear modes
    assign fetchChip1 = cfg.mode[0] ? videoAddr[15] : cfg.bufSel;

    always_ff @(posedge pixClk or negedge nReset) begin
        if (!nReset) begin
            vram <= '{nCe0: 1'b1, nCe1: 1'b1, nRd: 1'b1, nWr: 1'b1,
                      addr: '0, dataOut: '0, dataOe: 1'b0};
            served <= 1'b0;
            cpuDataOe <= 1'b0;
        end else begin
            // idle unless one of the cases below claims the bus
            vram.nCe0 <= 1'b1;
            vram.nCe1 <= 1'b1;
            vram.nRd <= 1'b1;
            vram.nWr <= 1'b1;
            vram.dataOe <= 1'b0;
            if (fetchSlot) begin
                // video read, vram answers during the next clock
                vram.nRd <= 1'b0;
                vram.addr <= videoAddr[14:0];
                vram.nCe0 <= fetchChip1;
                vram.nCe1 <= !fetchChip1;
            end else if (cpuServe && !regHit && !cpu.rnw) begin
                // single clock vram write
                vram.nWr <= 1'b0;
                vram.addr <= cpu.addr[14:0];
                vram.dataOut <= cpu.data;
                vram.dataOe <= 1'b1;
                vram.nCe0 <= cpu.addr[15];
                vram.nCe1 <= !cpu.addr[15];
            end
            // no vram reads from the cpu side, such a cycle is only acked
            if (!cpu.sel) begin
                served <= 1'b0;
                cpuDataOe <= 1'b0;
            end else if (cpuServe) begin
                served <= 1'b1;
                cpuDataOe <= regHit && cpu.rnw;
            end
        end
    end

    // status captured at the raster position the read was served
    always_ff @(posedge pixClk) begin
        if (cpuServe && regHit && cpu.rnw) begin
            cpuDataOut <= statusByte;
        end
    end

endmodule

`default_nettype wire

/* rtl/configRegs.sv */
`timescale 1ns/1ps
`default_nettype none

module configRegs import vidGenPkg::*; (
    input  wire logic       pixClk,
    input  wire logic       nReset,
    input  wire logic       regWrite,
    input  wire logic [7:0] writeData,
    input  rasterPos_t      pos,
    output vidConfig_t      cfg,
    output logic [7:0]      statusByte
);

    // bit 0 blank, bit 1 buffer select, bits 3:2 mode
    // upper nibble of a write is ignored
    always_ff @(posedge pixClk or negedge nReset) begin
        if (!nReset) begin
            cfg <= '0;
        end else if (regWrite) begin
            cfg.blank <= writeData[0];
            cfg.bufSel <= writeData[1];
            cfg.mode <= writeData[3:2];
        end
    end

    // read back: config in the low nibble, blanking flags above it
    // top two bits always read as ones
    assign statusByte = {
        2'b11,
        !pos.vActive,
        !pos.hActive,
        cfg.mode,
        cfg.bufSel,
        cfg.blank
    };

endmodule

`default_nettype wire

/* rtl/fetchAddress.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchAddress import vidGenPkg::*; (
    input  wire logic pixClk,
    input  wire logic nReset,
    input  rasterPos_t pos,
    input  vidConfig_t cfg,
    output logic [15:0] videoAddr
);

    logic addrStep;
    logic lineRewind;

    // advance after each fetch, on the last clock of the slot
    assign addrStep = pos.hActive && pos.vActive && (pos.phase == 2'd3);

    // line doubled modes replay the line just shown
    // only the even line rewinds, so the odd repeat moves on
    assign lineRewind = pos.vActive && !pos.vCount[0] && (pos.hCount == hVis) &&
                        !cfg.mode[0];

    always_ff @(posedge pixClk or negedge nReset) begin
        if (!nReset) begin
            videoAddr <= '0;
        end else if (!pos.vActive) begin
            // vertical blanking, next frame starts at byte 0
            videoAddr <= '0;
        end else if (addrStep) begin
            videoAddr <= videoAddr + 16'd1;
        end else if (lineRewind) begin
            videoAddr <= videoAddr - bytesPerLine;
        end
    end

    // in modes 1 and 3 the counter runs past 32K,
    // bit 15 then picks the chip in the sequencer

endmodule

`default_nettype wire

/* rtl/pixelSerializer.sv */
`timescale 1ns/1ps
`default_nettype none

module pixelSerializer import vidGenPkg::*; (
    input  wire logic       pixClk,
    input  wire logic       nReset,
    input  rasterPos_t      pos,
    input  vidConfig_t      cfg,
    input  wire logic [7:0] vramDataIn,
    output logic [3:0]      vidOut
);

    pixelByte_u pixByte;
    grayPair_t  grayPix;
    logic       inWindow;

    // byte fetched at phase 0 is on the vram bus during phase 1
    always_ff @(posedge pixClk) begin
        if (pos.hActive && pos.vActive && (pos.phase == 2'd1)) begin
            pixByte <= vramDataIn;
        end
    end

    // shown pixels trail the counter by the pipeline delay
    assign inWindow = pos.vActive && (pos.hCount >= pipeDelay) &&
                      (pos.hCount < hVis + pipeDelay);

    // phase 2 shows the leftmost pair, then 3, 0, 1
    assign grayPix = pixByte.gray[{pos.phase[1], ~pos.phase[0]}];

    always_ff @(posedge pixClk or negedge nReset) begin
        if (!nReset) begin
            vidOut <= 4'h0;
        end else if (!inWindow || cfg.blank) begin
            vidOut <= 4'h0;
        end else if (cfg.mode[1]) begin
            // grey, bright bit drives all three colours
            vidOut <= {grayPix.bright, grayPix.bright, grayPix.bright, grayPix.low};
        end else begin
            // rgbi, each nibble held for two clocks
            vidOut <= pixByte.rgbi[pos.phase[1]];
        end
    end

endmodule

`default_nettype wire

/* rtl/rasterTiming.sv */
`timescale 1ns/1ps
`default_nettype none

module rasterTiming import vidGenPkg::*; (
    input  wire logic pixClk,
    input  wire logic nReset,
    output rasterPos_t pos,
    output logic       vidH,
    output logic       vidV
);

    logic [9:0] hCount;
    logic [8:0] vCount;

    // pixel and line counters
    always_ff @(posedge pixClk or negedge nReset) begin
        if (!nReset) begin
            hCount <= '0;
            vCount <= '0;
        end else if (hCount == hTotal - 10'd1) begin
            hCount <= '0;
            // line wraps, step the frame
            if (vCount == vTotal - 9'd1) begin
                vCount <= '0;
            end else begin
                vCount <= vCount + 9'd1;
            end
        end else begin
            hCount <= hCount + 10'd1;
        end
    end

    // low two bits of the column pace the four-clock fetch slot
    assign pos = '{
        hCount:  hCount,
        vCount:  vCount,
        hActive: hCount < hVis,
        vActive: vCount < vVis,
        phase:   hCount[1:0]
    };

    // hsync negative, shifted by the fetch pipeline delay
    // vsync positive, whole lines
    always_ff @(posedge pixClk or negedge nReset) begin
        if (!nReset) begin
            vidH <= 1'b1;
            vidV <= 1'b0;
        end else begin
            vidH <= !((hCount >= hVis + hFront + pipeDelay) &&
                      (hCount < hVis + hFront + hSync + pipeDelay));
            vidV <= (vCount >= vVis + vFront) && (vCount < vVis + vFront + vSync);
        end
    end

endmodule

`default_nettype wire

/* rtl/vidGen.sv */
`timescale 1ns/1ps
`default_nettype none

module vidGen import vidGenPkg::*; (
    input  wire logic        pixClk,
    input  wire logic        nReset,
    input  wire logic        nCpuCE,
    input  wire logic        nCpuDS,
    input  wire logic        cpuRnW,
    input  wire logic [15:0] cpuAddr,
    input  wire logic [7:0]  cpuDataIn,
    input  wire logic [7:0]  vramDataIn,
    output logic [14:0]      vramAddr,
    output logic             nVramCE0,
    output logic             nVramCE1,
    output logic             nVramRd,
    output logic             nVramWr,
    output logic [7:0]       vramDataOut,
    output logic             vramDataOe,
    output logic [7:0]       cpuDataOut,
    output logic             cpuDataOe,
    output logic             nCpuDSACK,
    output logic [3:0]       vidOut,
    output logic             vidH,
    output logic             vidV
);

    rasterPos_t  pos;
    vidConfig_t  cfg;
    cpuReq_t     cpuReq;
    vramBus_t    vram;
    logic [15:0] videoAddr;
    logic        regWrite;
    logic [7:0]  statusByte;

    // a cycle is requested only while both strobes are low
    assign cpuReq = '{
        sel:  ~nCpuCE & ~nCpuDS,
        rnw:  cpuRnW,
        addr: cpuAddr,
        data: cpuDataIn
    };

    // vram pins straight from the sequencer registers
    assign vramAddr = vram.addr;
    assign nVramCE0 = vram.nCe0;
    assign nVramCE1 = vram.nCe1;
    assign nVramRd = vram.nRd;
    assign nVramWr = vram.nWr;
    assign vramDataOut = vram.dataOut;
    assign vramDataOe = vram.dataOe;

    rasterTiming rasterTiming_i (
        .pixClk (pixClk),
        .nReset (nReset),
        .pos    (pos),
        .vidH   (vidH),
        .vidV   (vidV)
    );

    configRegs configRegs_i (
        .pixClk     (pixClk),
        .nReset     (nReset),
        .regWrite   (regWrite),
        .writeData  (cpuReq.data),
        .pos        (pos),
        .cfg        (cfg),
        .statusByte (statusByte)
    );

    fetchAddress fetchAddress_i (
        .pixClk    (pixClk),
        .nReset    (nReset),
        .pos       (pos),
        .cfg       (cfg),
        .videoAddr (videoAddr)
    );

    busSequencer busSequencer_i (
        .pixClk     (pixClk),
        .nReset     (nReset),
        .pos        (pos),
        .cfg        (cfg),
        .videoAddr  (videoAddr),
        .cpu        (cpuReq),
        .statusByte (statusByte),
        .vram       (vram),
        .regWrite   (regWrite),
        .cpuDataOut (cpuDataOut),
        .cpuDataOe  (cpuDataOe),
        .nCpuDSACK  (nCpuDSACK)
    );

    pixelSerializer pixelSerializer_i (
        .pixClk     (pixClk),
        .nReset     (nReset),
        .pos        (pos),
        .cfg        (cfg),
        .vramDataIn (vramDataIn),
        .vidOut     (vidOut)
    );

endmodule

`default_nettype wire

/* rtl/vidGenPkg.sv */
`default_nettype none

package vidGenPkg;

    // horizontal timing, in pixel clocks
    localparam logic [9:0] hVis = 10'd640;
    localparam logic [9:0] hFront = 10'd16;
    localparam logic [9:0] hSync = 10'd96;
    localparam logic [9:0] hBack = 10'd48;
    // 800 clocks per line
    localparam logic [9:0] hTotal = hVis + hFront + hSync + hBack;

    // vertical timing, in lines
    localparam logic [8:0] vVis = 9'd400;
    localparam logic [8:0] vFront = 9'd12;
    localparam logic [8:0] vSync = 9'd2;
    localparam logic [8:0] vBack = 9'd35;
    // 449 lines per frame
    localparam logic [8:0] vTotal = vVis + vFront + vSync + vBack;

    // clocks from counter position to pixel on the pins
    localparam logic [9:0] pipeDelay = 10'd2;

    // one active line is 160 bytes of vram
    localparam logic [15:0] bytesPerLine = 16'd160;

    // control register sits at the top of the cpu window
    localparam logic [15:0] regAddr = 16'hFFFF;

    // raster position, shared by every block
    typedef struct packed {
        logic [9:0] hCount;
        logic [8:0] vCount;
        logic       hActive;
        logic       vActive;
        logic [1:0] phase;
    } rasterPos_t;

    // control register fields
    typedef struct packed {
        logic       blank;
        logic       bufSel;
        logic [1:0] mode;
    } vidConfig_t;

    // cpu bus request as seen by the sequencer
    typedef struct packed {
        logic        sel;
        logic        rnw;
        logic [15:0] addr;
        logic [7:0]  data;
    } cpuReq_t;

    // vram pins, registered in the sequencer
    typedef struct packed {
        logic        nCe0;
        logic        nCe1;
        logic        nRd;
        logic        nWr;
        logic [14:0] addr;
        logic [7:0]  dataOut;
        logic        dataOe;
    } vramBus_t;

    // one grey pixel: bright bit then low bit
    typedef struct packed {
        logic bright;
        logic low;
    } grayPair_t;

    // fetched byte, either two rgbi nibbles or four grey pairs
    // index 1 / index 3 is the leftmost pixel
    typedef union packed {
        logic [1:0][3:0] rgbi;
        grayPair_t [3:0] gray;
    } pixelByte_u;

endpackage

`default_nettype wire

/* verif/vidGenTb.sv */
`timescale 1ns/1ps
`default_nettype none

module vidGenTb import vidGenPkg::*; ();

    localparam int linePeriod = 800;
    localparam int framePeriod = 800 * 449;
    // three frames after reset release, then some slack
    localparam int cycleLimit = 3 * framePeriod + 122400;

    logic        pixClk;
    logic        nReset;
    logic        nCpuCE;
    logic        nCpuDS;
    logic        cpuRnW;
    logic [15:0] cpuAddr;
    logic [7:0]  cpuDataIn;
    logic [7:0]  vramDataIn;
    logic [14:0] vramAddr;
    logic        nVramCE0;
    logic        nVramCE1;
    logic        nVramRd;
    logic        nVramWr;
    logic [7:0]  vramDataOut;
    logic        vramDataOe;
    logic [7:0]  cpuDataOut;
    logic        cpuDataOe;
    logic        nCpuDSACK;
    logic [3:0]  vidOut;
    logic        vidH;
    logic        vidV;

    // two 32K chips where chip 1 also holds the upper half in linear modes
    logic [7:0]  vramChip0 [0:32767];
    logic [7:0]  vramChip1 [0:32767];
    vidConfig_t  expCfg;
    // edges seen since reset release
    int          cycleCount;
    int          clockTotal;
    int          errorCount;
    int          pixelChecks;
    int          vHighCount;

    vidGen vidGen_i (
        .pixClk      (pixClk),
        .nReset      (nReset),
        .nCpuCE      (nCpuCE),
        .nCpuDS      (nCpuDS),
        .cpuRnW      (cpuRnW),
        .cpuAddr     (cpuAddr),
        .cpuDataIn   (cpuDataIn),
        .vramDataIn  (vramDataIn),
        .vramAddr    (vramAddr),
        .nVramCE0    (nVramCE0),
        .nVramCE1    (nVramCE1),
        .nVramRd     (nVramRd),
        .nVramWr     (nVramWr),
        .vramDataOut (vramDataOut),
        .vramDataOe  (vramDataOe),
        .cpuDataOut  (cpuDataOut),
        .cpuDataOe   (cpuDataOe),
        .nCpuDSACK   (nCpuDSACK),
        .vidOut      (vidOut),
        .vidH        (vidH),
        .vidV        (vidV)
    );

    always #4 pixClk = ~pixClk;

    // asynchronous sram read with zero on an idle bus
    assign vramDataIn = (!nVramRd && !nVramCE0) ? vramChip0[vramAddr] :
                        (!nVramRd && !nVramCE1) ? vramChip1[vramAddr] : 8'h00;

    always @(posedge pixClk) begin
        if (!nVramWr && !nVramCE0) begin
            vramChip0[vramAddr] <= vramDataOut;
        end
        if (!nVramWr && !nVramCE1) begin
            vramChip1[vramAddr] <= vramDataOut;
        end
    end

    always @(posedge pixClk) begin
        clockTotal <= clockTotal + 1;
        if (nReset) begin
            cycleCount <= cycleCount + 1;
        end
    end

    task automatic finishRun();
        $display("pixel checks %0d, errors %0d", pixelChecks, errorCount);
        if (errorCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    always @(posedge pixClk) begin
        if (clockTotal == cycleLimit) begin
            $display("timeout, the test sequence did not end within %0d cycles", cycleLimit);
            errorCount = errorCount + 1;
            finishRun();
        end
    end

    task automatic valueError(input string name, input logic [15:0] expVal,
                              input logic [15:0] gotVal);
        errorCount = errorCount + 1;
        $display("error %s: expected %h, got %h at cycle %0d", name, expVal, gotVal,
                 cycleCount);
    endtask

    // pixel at a screen column and line with 0 for blank and borders
    function automatic logic [3:0] expectedPixel(input int column, input int line,
                                                 input vidConfig_t cfg);
        int         byteAddr;
        logic       chipSel;
        logic [7:0] pixByte;
        logic [1:0] pair;
        if (line >= 400 || column < 0 || column >= 640 || cfg.blank) begin
            return 4'h0;
        end
        // linear modes step a full line per line and doubled modes every second line
        if (cfg.mode[0]) begin
            byteAddr = line * 160 + column / 4;
            chipSel = byteAddr[15];
        end else begin
            byteAddr = (line / 2) * 160 + column / 4;
            chipSel = cfg.bufSel;
        end
        pixByte = chipSel ? vramChip1[byteAddr[14:0]] : vramChip0[byteAddr[14:0]];
        if (cfg.mode[1]) begin
            // four grey pixels with the leftmost in the top pair
            pair = pixByte[7 - 2 * (column % 4) -: 2];
            return {pair[1], pair[1], pair[1], pair[0]};
        end
        return (column % 4 < 2) ? pixByte[7:4] : pixByte[3:0];
    endfunction

    // sampled at the negedge when outputs have settled
    always @(negedge pixClk) begin : compareOutputs
        int         k;
        int         h;
        int         v;
        logic [3:0] expPix;
        logic       expH;
        logic       expV;
        if (nReset && cycleCount > 0) begin
            k = cycleCount - 1;
            h = k % linePeriod;
            v = (k / linePeriod) % 449;
            expPix = expectedPixel(h - 2, v, expCfg);
            expH = !(h >= 658 && h < 754);
            expV = (v == 412) || (v == 413);
            pixelChecks = pixelChecks + 1;
            if (vidOut !== expPix) begin
                valueError("vidOut", expPix, vidOut);
            end
            if (vidH !== expH) begin
                valueError("vidH", expH, vidH);
            end
            if (vidV !== expV) begin
                valueError("vidV", expV, vidV);
            end
            // data drive on the vram bus only during a write strobe
            if (vramDataOe !== !nVramWr) begin
                valueError("vramDataOe", !nVramWr, vramDataOe);
            end
            if (h == 0 && v == 0) begin
                vHighCount = 0;
            end
            if (vidV === 1'b1) begin
                vHighCount = vHighCount + 1;
            end
            if (h == 799 && v == 448 && vHighCount != 2 * linePeriod) begin
                errorCount = errorCount + 1;
                $display("vsync was high for %0d cycles in one frame instead of 1600",
                         vHighCount);
            end
        end
    end

    task automatic checkResetValues();
        if (nVramCE0 !== 1'b1) valueError("nVramCE0", 1, nVramCE0);
        if (nVramCE1 !== 1'b1) valueError("nVramCE1", 1, nVramCE1);
        if (nVramRd !== 1'b1) valueError("nVramRd", 1, nVramRd);
        if (nVramWr !== 1'b1) valueError("nVramWr", 1, nVramWr);
        if (nCpuDSACK !== 1'b1) valueError("nCpuDSACK", 1, nCpuDSACK);
        if (vramDataOe !== 1'b0) valueError("vramDataOe", 0, vramDataOe);
        if (cpuDataOe !== 1'b0) valueError("cpuDataOe", 0, cpuDataOe);
        if (vidV !== 1'b0) valueError("vidV", 0, vidV);
        if (vidH !== 1'b1) valueError("vidH", 1, vidH);
        if (vidOut !== 4'h0) valueError("vidOut", 0, vidOut);
    endtask

    // one full strobe cycle that reports the raster index of the serving edge in servedAt
    task automatic cpuAccess(input logic [15:0] addr, input logic rnw, input logic [7:0] data,
                             output logic [7:0] readData, output int servedAt);
        int waitCycles;
        waitCycles = 0;
        @(posedge pixClk);
        #1;
        nCpuCE = 1'b0;
        nCpuDS = 1'b0;
        cpuRnW = rnw;
        cpuAddr = addr;
        cpuDataIn = data;
        while (nCpuDSACK === 1'b1 && waitCycles < 4) begin
            @(posedge pixClk);
            #1;
            waitCycles = waitCycles + 1;
        end
        if (waitCycles > 2) begin
            errorCount = errorCount + 1;
            $display("no acknowledge within two cycles for cpu address %h", addr);
        end
        servedAt = cycleCount - 1;
        readData = cpuDataOut;
        // cpu data is driven only for a register read
        if (cpuDataOe !== (rnw && addr == 16'hFFFF)) begin
            valueError("cpuDataOe", rnw && addr == 16'hFFFF, cpuDataOe);
        end
        nCpuCE = 1'b1;
        nCpuDS = 1'b1;
        @(posedge pixClk);
        #1;
        // ack and data drive end one clock after the strobe rises
        if (nCpuDSACK !== 1'b1) valueError("nCpuDSACK", 1, nCpuDSACK);
        if (cpuDataOe !== 1'b0) valueError("cpuDataOe", 0, cpuDataOe);
    endtask

    task automatic writeConfig(input logic [7:0] value);
        logic [7:0] ignored;
        int         at;
        cpuAccess(16'hFFFF, 1'b0, value, ignored, at);
        expCfg.blank = value[0];
        expCfg.bufSel = value[1];
        expCfg.mode = value[3:2];
    endtask

    task automatic readStatusCheck();
        logic [7:0] rd;
        logic [7:0] expStatus;
        int         at;
        int         h;
        int         v;
        cpuAccess(16'hFFFF, 1'b1, 8'h00, rd, at);
        h = at % linePeriod;
        v = (at / linePeriod) % 449;
        expStatus = {2'b11, v >= 400, h >= 640, expCfg.mode, expCfg.bufSel, expCfg.blank};
        if (rd !== expStatus) valueError("cpuDataOut", expStatus, rd);
    endtask

    task automatic vramWriteCheck(input logic [15:0] addr, input logic [7:0] data);
        logic [7:0] rd;
        logic [7:0] otherOld;
        int         at;
        otherOld = addr[15] ? vramChip0[addr[14:0]] : vramChip1[addr[14:0]];
        cpuAccess(addr, 1'b0, data, rd, at);
        if (addr[15]) begin
            if (vramChip1[addr[14:0]] !== data) begin
                valueError("vramChip1", data, vramChip1[addr[14:0]]);
            end
            if (vramChip0[addr[14:0]] !== otherOld) begin
                valueError("vramChip0", otherOld, vramChip0[addr[14:0]]);
            end
        end else begin
            if (vramChip0[addr[14:0]] !== data) begin
                valueError("vramChip0", data, vramChip0[addr[14:0]]);
            end
            if (vramChip1[addr[14:0]] !== otherOld) begin
                valueError("vramChip1", otherOld, vramChip1[addr[14:0]]);
            end
        end
    endtask

    // returns one ns after the edge before the first clock of that line
    task automatic waitForLine(input int line);
        while (((cycleCount / linePeriod) % 449) != line) begin
            @(posedge pixClk);
            #1;
        end
    endtask

    initial begin
        int          seedDummy;
        int          i;
        logic [15:0] addr;
        pixClk = 1'b0;
        nReset = 1'b0;
        nCpuCE = 1'b1;
        nCpuDS = 1'b1;
        cpuRnW = 1'b1;
        cpuAddr = 16'h0000;
        cpuDataIn = 8'h00;
        cycleCount = 0;
        clockTotal = 0;
        errorCount = 0;
        pixelChecks = 0;
        vHighCount = 0;
        expCfg = '0;
        seedDummy = $urandom(32'h7dd3_35bc);
        for (i = 0; i < 32768; i++) begin
            vramChip0[i] = 8'($urandom);
            vramChip1[i] = 8'($urandom);
        end

        repeat (8) @(posedge pixClk);
        @(negedge pixClk);
        checkResetValues();
        repeat (8) @(posedge pixClk);
        #1;
        nReset = 1'b1;
        // still idle until the first edge after release
        @(negedge pixClk);
        checkResetValues();

        // mode 1 is in place before the rewind column of line 0
        // line 0 reads the same bytes in modes 0 and 1, so frame 0 is linear 4bpp
        writeConfig(8'h04);

        // status reads at random raster positions of frame 0
        for (i = 0; i < 4; i++) begin
            repeat ($urandom_range(0, 20000)) @(posedge pixClk);
            readStatusCheck();
        end

        // register round trips and cpu vram writes in the vertical blank of frame 0
        waitForLine(402);
        for (i = 0; i < 4; i++) begin
            writeConfig(8'($urandom));
            repeat ($urandom_range(0, 300)) @(posedge pixClk);
            readStatusCheck();
        end
        for (i = 0; i < 12; i++) begin
            addr = 16'($urandom);
            addr[15] = i[0];
            if (addr == 16'hFFFF) begin
                addr = 16'hFFFE;
            end
            vramWriteCheck(addr, 8'($urandom));
        end

        // frame 1 grey doubled from chip 1
        writeConfig(8'h0A);
        waitForLine(0);
        waitForLine(401);
        // frame 2 blanked throughout
        writeConfig(8'h0B);
        waitForLine(0);
        waitForLine(401);
        @(negedge pixClk);
        #1;
        finishRun();
    end

endmodule

`default_nettype wire

/* verif/vidGen_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module vidGenAssertions (
    input wire logic pixClk,
    input wire logic nReset,
    input wire logic nRd,
    input wire logic nWr,
    input wire logic nCe0,
    input wire logic nCe1,
    input wire logic hSyncN
);

    logic [7:0] syncLowLen;

    // clocks spent low in the current hsync pulse
    always_ff @(posedge pixClk or negedge nReset) begin
        if (!nReset) begin
            syncLowLen <= '0;
        end else if (hSyncN) begin
            syncLowLen <= '0;
        end else begin
            syncLowLen <= syncLowLen + 8'd1;
        end
    end

    // a vram cycle is either a read or a write
    strobeExclusive: assert property (@(posedge pixClk) disable iff (!nReset) nRd || nWr)
        else $error("vram read and write strobes low together");

    chipExclusive: assert property (@(posedge pixClk) disable iff (!nReset) nCe0 || nCe1)
        else $error("both vram chip enables low");

    hSyncWidth: assert property (@(posedge pixClk) disable iff (!nReset)
        $rose(hSyncN) |-> syncLowLen == 8'd96)
        else $error("hsync pulse lasted %0d clocks", syncLowLen);

endmodule

// bus checks only, the sync input idles high
bind busSequencer vidGenAssertions busChecks_i (
    .pixClk (pixClk),
    .nReset (nReset),
    .nRd    (vram.nRd),
    .nWr    (vram.nWr),
    .nCe0   (vram.nCe0),
    .nCe1   (vram.nCe1),
    .hSyncN (1'b1)
);

// sync checks only, strobes idle high
bind rasterTiming vidGenAssertions syncChecks_i (
    .pixClk (pixClk),
    .nReset (nReset),
    .nRd    (1'b1),
    .nWr    (1'b1),
    .nCe0   (1'b1),
    .nCe1   (1'b1),
    .hSyncN (vidH)
);

`default_nettype wire
